//--- source/if_ctrl_pkg.sv
// Fetch control definitions
// PC mux codes, trap vector constants and address widths used by
// the next-PC selection

package if_ctrl_pkg;

  ////////////////////
  // Widths
  ////////////////////

  localparam int ADDR_W    = 32;  // Fetch address width
  localparam int MTVEC_W   = 25;  // mtvec base field, bits [31:7]
  localparam int IRQ_IDX_W = 5;   // Vectored interrupt index

  // Fixed vector slot for NMI, sits in the mtvec table
  localparam logic [IRQ_IDX_W-1:0] NMI_MTVEC_INDEX = 5'd15;

  ////////////////////
  // Redirect source
  ////////////////////

  typedef enum logic [3:0] {
    PC_BOOT     = 4'd0,  // Boot address after reset
    PC_JUMP     = 4'd1,  // Jump target from ID
    PC_BRANCH   = 4'd2,  // Taken branch from EX
    PC_MRET     = 4'd3,  // Return from trap
    PC_DRET     = 4'd4,  // Return from debug mode
    PC_TRAP_EXC = 4'd5,  // Exception, mtvec base
    PC_TRAP_IRQ = 4'd6,  // Vectored interrupt
    PC_TRAP_DBD = 4'd7,  // Debug halt entry
    PC_TRAP_DBE = 4'd8,  // Exception while in debug mode
    PC_TRAP_NMI = 4'd9   // Non-maskable interrupt
  } pc_mux_e;

endpackage

//--- source/instr_bus_pkg.sv
// Instruction bus types
// Address and word types of the fetch bus, plus the fetch entry that
// moves from the prefetch buffer into the IF/ID register

package instr_bus_pkg;

  ////////////////////
  // Bus words
  ////////////////////

  typedef logic [31:0] addr_t;  // Byte address on the bus
  typedef logic [31:0] word_t;  // One 32-bit instruction

  ////////////////////
  // Fetch entry
  ////////////////////

  // Response payload as kept in the buffer, 33 bits
  typedef struct packed {
    word_t rdata;  // Instruction word from the bus
    logic  err;    // Bus error on this fetch
  } fetch_entry_t;

  // Entry width, handy for storage sizing
  localparam int FETCH_ENTRY_W = $bits(fetch_entry_t);

endpackage

//--- source/fetch_if.sv
// Fetch handshake between prefetch buffer and IF/ID register
// Valid/ready with the instruction and its PC

`timescale 1ns/1ps

interface fetch_if;

  import instr_bus_pkg::*;

  logic         valid;  // Buffer holds an instruction
  logic         ready;  // IF/ID takes it this cycle
  addr_t        pc;     // Address of the head instruction
  fetch_entry_t entry;  // Instruction word and error flag

  // Prefetch side
  modport source (
    output valid,
    output pc,
    output entry,
    input  ready
  );

  // Pipeline register side
  modport sink (
    input  valid,
    input  pc,
    input  entry,
    output ready
  );

endinterface

//--- source/pc_select.sv
// Next fetch address selection
// Picks the redirect target from the controller's mux code, builds trap
// vectors from mtvec and raises the mtvec init pulse on boot

`timescale 1ns/1ps

module pc_select (
  input  logic                               pc_set_i,         // Redirect strobe
  input  if_ctrl_pkg::pc_mux_e               pc_mux_i,         // Redirect source
  input  logic [if_ctrl_pkg::IRQ_IDX_W-1:0]  irq_index_i,      // Vectored IRQ slot
  input  instr_bus_pkg::addr_t               boot_addr_i,
  input  instr_bus_pkg::addr_t               jump_target_i,
  input  instr_bus_pkg::addr_t               branch_target_i,
  input  instr_bus_pkg::addr_t               mepc_i,
  input  instr_bus_pkg::addr_t               dpc_i,
  input  logic [if_ctrl_pkg::MTVEC_W-1:0]    mtvec_addr_i,     // mtvec base, bits [31:7]
  input  instr_bus_pkg::addr_t               dm_halt_addr_i,
  input  instr_bus_pkg::addr_t               dm_exception_addr_i,
  output instr_bus_pkg::addr_t               branch_addr_o,    // Word aligned target
  output logic                               csr_mtvec_init_o  // Boot pulse to CSRs
);

  import if_ctrl_pkg::*;

  logic [ADDR_W-1:0] target;  // Raw target before alignment

  ////////////////////
  // Target mux
  ////////////////////

  always_comb begin
    target = boot_addr_i;
    unique case (pc_mux_i)
      PC_BOOT:     target = boot_addr_i;
      PC_JUMP:     target = jump_target_i;
      PC_BRANCH:   target = branch_target_i;
      PC_MRET:     target = mepc_i;                               // Back to trapped PC
      PC_DRET:     target = dpc_i;                                // Leave debug mode
      PC_TRAP_EXC: target = {mtvec_addr_i, 7'h00};                // All exceptions share base
      PC_TRAP_IRQ: target = {mtvec_addr_i, irq_index_i, 2'b00};   // One slot per IRQ
      PC_TRAP_DBD: target = dm_halt_addr_i;
      PC_TRAP_DBE: target = dm_exception_addr_i;
      PC_TRAP_NMI: target = {mtvec_addr_i, NMI_MTVEC_INDEX, 2'b00};
      default:     target = boot_addr_i;
    endcase
  end

  // Only 32-bit fetch, low bits always dropped
  assign branch_addr_o = {target[ADDR_W-1:2], 2'b00};

  // CSR file loads mtvec default on the boot redirect
  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == PC_BOOT);

  // Controller must present a real code with every redirect
  always_comb begin
    if (pc_set_i) begin
      a_mux_known : assert final (!$isunknown(pc_mux_i))
        else $error("pc_select: unknown pc_mux_i with pc_set_i");
    end
  end

endmodule

//--- source/sync_fifo.sv
// Synchronous FIFO
// Circular buffer with occupancy count and single-cycle flush,
// payload type set by parameter

`timescale 1ns/1ps

module sync_fifo #(
  parameter int  DEPTH     = 2,
  parameter type payload_t = logic [31:0]
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       flush_i,  // Drop all entries
  input  logic                       push_i,
  input  payload_t                   data_i,
  input  logic                       pop_i,
  output payload_t                   data_o,   // Head entry
  output logic                       empty_o,
  output logic                       full_o,
  output logic [$clog2(DEPTH+1)-1:0] count_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);  // Wrap point

  payload_t         mem_q [DEPTH];  // Storage
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign do_push = push_i && (!full_o || pop_i);  // Full is fine if head leaves
  assign do_pop  = pop_i && !empty_o;

  ////////////////////
  // Pointers
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= (wr_ptr_q == LAST) ? '0 : wr_ptr_q + 1'b1;
      if (do_pop)  rd_ptr_q <= (rd_ptr_q == LAST) ? '0 : rd_ptr_q + 1'b1;
      count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  always_ff @(posedge clk) begin
    if (do_push && !flush_i) mem_q[wr_ptr_q] <= data_i;
  end

  assign data_o  = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign count_o = count_q;

  a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
    (push_i && full_o && !flush_i) |-> pop_i)
    else $error("sync_fifo: push while full");

  a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n)
    pop_i |-> !empty_o)
    else $error("sync_fifo: pop while empty");

endmodule

//--- source/prefetch_unit.sv
// Prefetch unit
// Issues word reads on the request/grant bus, tracks outstanding reads,
// drops responses that belong to an old fetch stream, buffers the rest

`timescale 1ns/1ps

module prefetch_unit #(
  parameter int PF_DEPTH = 2
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 pc_set_i,       // Redirect
  input  instr_bus_pkg::addr_t branch_addr_i,  // Aligned redirect target
  output logic                 req_o,
  output instr_bus_pkg::addr_t addr_o,
  input  logic                 gnt_i,
  input  logic                 rvalid_i,
  input  instr_bus_pkg::word_t rdata_i,
  input  logic                 err_i,
  output logic                 busy_o,         // Reads in flight
  fetch_if.source              fetch
);

  import instr_bus_pkg::*;

  localparam int CNT_W = $clog2(PF_DEPTH + 1);

  addr_t            fetch_addr_q;  // Next address to request
  addr_t            stale_addr_q;  // Old address of a request caught by redirect
  addr_t            head_pc_q;     // PC of the buffer head
  addr_t            resp_addr;     // Address of the response now arriving
  logic             started_q;     // Fetching enabled by the first redirect
  logic             stale_q;       // Pending request is from the old stream
  logic             pend_q;        // Request up last cycle without grant
  logic [CNT_W-1:0] discard_q;     // Responses still to drop
  logic [CNT_W-1:0] outst_cnt;
  logic [CNT_W-1:0] buf_cnt;
  logic [CNT_W:0]   used;
  logic             can_issue;
  logic             grant;
  logic             drop;
  logic             accept;
  logic             pop_buf;
  logic             addr_empty;
  logic             buf_empty;
  fetch_entry_t     resp_entry;
  fetch_entry_t     head_entry;

  ////////////////////
  // Request side
  ////////////////////

  assign used      = {1'b0, buf_cnt} + {1'b0, outst_cnt};
  assign can_issue = used < (CNT_W+1)'(PF_DEPTH);           // Room for one more word
  assign req_o     = stale_q || pend_q || (started_q && can_issue && !pc_set_i);
  assign addr_o    = stale_q ? stale_addr_q : fetch_addr_q;  // Held until granted
  assign grant     = req_o && gnt_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_addr_q <= '0;
      started_q    <= 1'b0;
      stale_q      <= 1'b0;
      pend_q       <= 1'b0;
      discard_q    <= '0;
    end else begin
      pend_q <= req_o && !gnt_i;
      if (pc_set_i) begin
        fetch_addr_q <= branch_addr_i;
        started_q    <= 1'b1;
        stale_q      <= req_o && !gnt_i;  // Ungranted request must still complete
        // Everything in flight after this cycle is old
        discard_q    <= CNT_W'({1'b0, outst_cnt} + (CNT_W+1)'(grant) - (CNT_W+1)'(rvalid_i));
      end else begin
        if (grant && !stale_q) fetch_addr_q <= fetch_addr_q + 32'd4;
        if (grant)             stale_q      <= 1'b0;
        discard_q <= discard_q + CNT_W'(grant && stale_q) - CNT_W'(rvalid_i && drop);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pc_set_i && req_o && !gnt_i && !stale_q) stale_addr_q <= addr_o;
  end

  ////////////////////
  // Response side
  ////////////////////

  assign drop       = (discard_q != '0);
  assign accept     = rvalid_i && !drop && !pc_set_i;
  assign resp_entry = '{rdata: rdata_i, err: err_i};
  assign busy_o     = !addr_empty;

  // Outstanding addresses in grant order
  sync_fifo #(.DEPTH(PF_DEPTH), .payload_t(addr_t)) u_addr_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (1'b0),        // Stale entries drain with their responses
    .push_i  (grant),
    .data_i  (addr_o),
    .pop_i   (rvalid_i),
    .data_o  (resp_addr),
    .empty_o (addr_empty),
    .full_o  (),
    .count_o (outst_cnt)
  );

  // Buffered instructions
  sync_fifo #(.DEPTH(PF_DEPTH), .payload_t(fetch_entry_t)) u_instr_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (pc_set_i),
    .push_i  (accept),
    .data_i  (resp_entry),
    .pop_i   (pop_buf),
    .data_o  (head_entry),
    .empty_o (buf_empty),
    .full_o  (),
    .count_o (buf_cnt)
  );

  // Buffered words are always consecutive so the head PC steps by 4
  always_ff @(posedge clk) begin
    if (accept && buf_empty) head_pc_q <= resp_addr;
    else if (pop_buf)        head_pc_q <= head_pc_q + 32'd4;
  end

  assign fetch.valid = !buf_empty;
  assign fetch.pc    = head_pc_q;
  assign fetch.entry = head_entry;
  assign pop_buf     = fetch.valid && fetch.ready;

  a_rvalid_outst : assert property (@(posedge clk) disable iff (!rst_n)
    rvalid_i |-> !addr_empty)
    else $error("prefetch_unit: response with no read outstanding");

  a_req_stable : assert property (@(posedge clk) disable iff (!rst_n)
    (req_o && !gnt_i) |=> (req_o && $stable(addr_o)))
    else $error("prefetch_unit: request dropped or moved before grant");

endmodule

//--- source/if_id_reg.sv
// IF/ID pipeline register
// Takes the buffer head when ID is ready, holds while ID stalls,
// blocked by halt and emptied by kill

`timescale 1ns/1ps

module if_id_reg (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 kill_if_i,   // Flush IF
  input  logic                 halt_if_i,   // Stop issuing into ID
  input  logic                 id_ready_i,  // ID can take an instruction
  fetch_if.sink                fetch,
  output logic                 id_valid_o,
  output instr_bus_pkg::addr_t id_pc_o,
  output instr_bus_pkg::word_t id_instr_o,
  output logic                 id_err_o
);

  import instr_bus_pkg::*;

  logic         take;     // Load a new instruction
  addr_t        pc_q;
  fetch_entry_t entry_q;

  // Kill accepts and throws away the head entry
  assign fetch.ready = (id_ready_i && !halt_if_i) || kill_if_i;
  assign take        = fetch.valid && fetch.ready && !kill_if_i;

  ////////////////////
  // Valid bit
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_o <= 1'b0;
    end else if (kill_if_i) begin
      id_valid_o <= 1'b0;
    end else if (take) begin
      id_valid_o <= 1'b1;
    end else if (id_ready_i) begin
      id_valid_o <= 1'b0;       // ID consumed it, nothing new
    end
  end

  // Payload, frozen while ID stalls
  always_ff @(posedge clk) begin
    if (take) begin
      pc_q    <= fetch.pc;
      entry_q <= fetch.entry;
    end
  end

  assign id_pc_o    = pc_q;
  assign id_instr_o = entry_q.rdata;
  assign id_err_o   = entry_q.err;

  a_pc_aligned : assert property (@(posedge clk) disable iff (!rst_n)
    id_valid_o |-> (id_pc_o[1:0] == 2'b00))
    else $error("if_id_reg: misaligned PC handed to ID");

endmodule

//--- source/if_stage.sv
// Instruction fetch stage
// Next-PC selection, prefetch unit and IF/ID register for 32-bit code
// on a request/grant instruction bus

`timescale 1ns/1ps

module if_stage #(
  parameter int PF_DEPTH = 2  // Buffer depth and outstanding bound
) (
  input  logic                              clk,
  input  logic                              rst_n,
  // Controller
  input  logic                              pc_set_i,
  input  if_ctrl_pkg::pc_mux_e              pc_mux_i,
  input  logic [if_ctrl_pkg::IRQ_IDX_W-1:0] irq_index_i,
  input  logic                              kill_if_i,
  input  logic                              halt_if_i,
  input  logic                              id_ready_i,
  // Redirect targets
  input  instr_bus_pkg::addr_t              boot_addr_i,
  input  instr_bus_pkg::addr_t              jump_target_i,
  input  instr_bus_pkg::addr_t              branch_target_i,
  input  instr_bus_pkg::addr_t              mepc_i,
  input  instr_bus_pkg::addr_t              dpc_i,
  input  logic [if_ctrl_pkg::MTVEC_W-1:0]   mtvec_addr_i,
  input  instr_bus_pkg::addr_t              dm_halt_addr_i,
  input  instr_bus_pkg::addr_t              dm_exception_addr_i,
  // Instruction bus
  output logic                              instr_req_o,
  output instr_bus_pkg::addr_t              instr_addr_o,
  input  logic                              instr_gnt_i,
  input  logic                              instr_rvalid_i,
  input  instr_bus_pkg::word_t              instr_rdata_i,
  input  logic                              instr_err_i,
  // To ID and CSRs
  output logic                              id_valid_o,
  output instr_bus_pkg::addr_t              id_pc_o,
  output instr_bus_pkg::word_t              id_instr_o,
  output logic                              id_err_o,
  output logic                              if_busy_o,
  output logic                              csr_mtvec_init_o
);

  import instr_bus_pkg::*;

  addr_t branch_addr;  // Aligned redirect target

  fetch_if fetch_bus ();

  pc_select u_pc_select (
    .pc_set_i            (pc_set_i),
    .pc_mux_i            (pc_mux_i),
    .irq_index_i         (irq_index_i),
    .boot_addr_i         (boot_addr_i),
    .jump_target_i       (jump_target_i),
    .branch_target_i     (branch_target_i),
    .mepc_i              (mepc_i),
    .dpc_i               (dpc_i),
    .mtvec_addr_i        (mtvec_addr_i),
    .dm_halt_addr_i      (dm_halt_addr_i),
    .dm_exception_addr_i (dm_exception_addr_i),
    .branch_addr_o       (branch_addr),
    .csr_mtvec_init_o    (csr_mtvec_init_o)
  );

  prefetch_unit #(.PF_DEPTH(PF_DEPTH)) u_prefetch (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_set_i      (pc_set_i),
    .branch_addr_i (branch_addr),
    .req_o         (instr_req_o),
    .addr_o        (instr_addr_o),
    .gnt_i         (instr_gnt_i),
    .rvalid_i      (instr_rvalid_i),
    .rdata_i       (instr_rdata_i),
    .err_i         (instr_err_i),
    .busy_o        (if_busy_o),
    .fetch         (fetch_bus)
  );

  if_id_reg u_if_id (
    .clk        (clk),
    .rst_n      (rst_n),
    .kill_if_i  (kill_if_i),
    .halt_if_i  (halt_if_i),
    .id_ready_i (id_ready_i),
    .fetch      (fetch_bus),
    .id_valid_o (id_valid_o),
    .id_pc_o    (id_pc_o),
    .id_instr_o (id_instr_o),
    .id_err_o   (id_err_o)
  );

endmodule

//--- sim/tb_if_stage.sv
// Fetch stage testbench
// Random redirects and ID stalls against a bus memory model with
// random grant and response delay, checked by a reference PC model

`timescale 1ns/1ps

module tb_if_stage;

  import if_ctrl_pkg::*;
  import instr_bus_pkg::*;

  localparam int PF_DEPTH = 2;
  localparam int N_REDIR  = 40;                        // Redirects in the run
  localparam int MAX_OUT  = 12;                        // Most outputs per redirect
  localparam int TIMEOUT  = N_REDIR * MAX_OUT * 20;    // Cycle limit
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;   // x^32+x^22+x^2+x+1

  logic                 clk;
  logic                 rst_n;
  logic                 pc_set_i, kill_if_i, halt_if_i, id_ready_i;
  pc_mux_e              pc_mux_i;
  logic [IRQ_IDX_W-1:0] irq_index_i;
  logic [MTVEC_W-1:0]   mtvec_addr_i;
  addr_t                boot_addr_i, jump_target_i, branch_target_i, mepc_i, dpc_i;
  addr_t                dm_halt_addr_i, dm_exception_addr_i;
  logic                 instr_req_o, instr_gnt_i, instr_rvalid_i, instr_err_i;
  addr_t                instr_addr_o;
  word_t                instr_rdata_i;
  logic                 id_valid_o, id_err_o, if_busy_o, csr_mtvec_init_o;
  addr_t                id_pc_o;
  word_t                id_instr_o;

  logic [31:0] lfsr_q = 32'hc46f_b5f0;  // Random state
  addr_t       gnt_addr_q[$];           // Granted reads, in order
  int          gnt_due_q[$];            // Cycle each response is due
  logic        bus_on = 1'b0;           // Memory grants only after first redirect
  logic        redirected = 1'b0;
  addr_t       exp_pc;                  // Next PC expected at ID
  int          cyc = 0;
  int          n_out;
  // Previous cycle values for hold and bus checks
  logic        prev_req = 1'b0, prev_gnt, prev_valid = 1'b0, prev_ready, prev_kill;
  logic        prev_halt = 1'b0, prev_err;
  addr_t       prev_addr, prev_pc;
  word_t       prev_instr;

  if_stage #(.PF_DEPTH(PF_DEPTH)) u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic next_bit();
    logic fb;
    fb     = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (fb) lfsr_q = lfsr_q ^ LFSR_TAPS;  // Galois feedback
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], next_bit()};
    return v;
  endfunction

  function automatic word_t mem_word(input addr_t a);
    return a ^ 32'h5a5a_a5a5;
  endfunction

  function automatic logic mem_err(input addr_t a);
    return a[6] & a[9];  // Error region
  endfunction

  // Expected redirect target
  function automatic addr_t redirect_target(input pc_mux_e code);
    addr_t t;
    case (code)
      PC_BOOT:     t = boot_addr_i;
      PC_JUMP:     t = jump_target_i;
      PC_BRANCH:   t = branch_target_i;
      PC_MRET:     t = mepc_i;
      PC_DRET:     t = dpc_i;
      PC_TRAP_EXC: t = {mtvec_addr_i, 7'b000_0000};
      PC_TRAP_IRQ: t = {mtvec_addr_i, irq_index_i, 2'b00};
      PC_TRAP_DBD: t = dm_halt_addr_i;
      PC_TRAP_DBE: t = dm_exception_addr_i;
      PC_TRAP_NMI: t = {mtvec_addr_i, NMI_MTVEC_INDEX, 2'b00};
      default:     t = boot_addr_i;
    endcase
    t[1:0] = 2'b00;  // Word fetch only
    return t;
  endfunction

  task automatic abort_run();
    $display("test failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    assert (got === exp)
      else begin
        $display("ERR t=%0t %s exp=%b got=%b", $time, name, exp, got);
        abort_run();
      end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp)
      else begin
        $display("ERR t=%0t %s exp=%h got=%h", $time, name, exp, got);
        abort_run();
      end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond)
      else begin
        $display("Check failed at t=%0t: %s", $time, what);
        abort_run();
      end
  endtask

  ////////////////////
  // Per-cycle drive and check
  ////////////////////

  task automatic pick_redirect();
    logic [3:0] code;
    code                = 4'(rand_bits(4) % 10);
    pc_mux_i            = pc_mux_e'(code);
    irq_index_i         = 5'(rand_bits(5));
    mtvec_addr_i        = 25'(rand_bits(25));
    boot_addr_i         = rand_bits(32);
    jump_target_i       = rand_bits(32);
    branch_target_i     = rand_bits(32);
    mepc_i              = rand_bits(32);
    dpc_i               = rand_bits(32);
    dm_halt_addr_i      = rand_bits(32);
    dm_exception_addr_i = rand_bits(32);
    exp_pc              = redirect_target(pc_mux_e'(code));
    bus_on              = 1'b1;
    redirected          = 1'b1;
  endtask

  // Memory side returns responses in grant order once due
  task automatic drive_bus();
    instr_gnt_i = bus_on && (rand_bits(2) != 0);
    if (gnt_addr_q.size() > 0 && gnt_due_q[0] <= cyc) begin
      instr_rvalid_i = 1'b1;
      instr_rdata_i  = mem_word(gnt_addr_q[0]);
      instr_err_i    = mem_err(gnt_addr_q[0]);
      void'(gnt_addr_q.pop_front());
      void'(gnt_due_q.pop_front());
    end else begin
      instr_rvalid_i = 1'b0;
      instr_rdata_i  = '0;
      instr_err_i    = 1'b0;
    end
  endtask

  task automatic sample_cycle();
    logic consumed;
    check_bit("csr_mtvec_init_o", pc_set_i && (pc_mux_i == PC_BOOT), csr_mtvec_init_o);
    if (!redirected) begin  // Idle until the first redirect
      check_bit("id_valid_o", 1'b0, id_valid_o);
      check_bit("instr_req_o", 1'b0, instr_req_o);
    end
    if (prev_req && !prev_gnt) begin  // Address phase still open
      check_bit("instr_req_o", 1'b1, instr_req_o);
      check_word("instr_addr_o", prev_addr, instr_addr_o);
    end
    // Reads granted earlier and not yet answered, this cycle's response included
    check_bit("if_busy_o", gnt_addr_q.size() > 0 || instr_rvalid_i, if_busy_o);
    if (instr_req_o && instr_gnt_i) begin
      gnt_addr_q.push_back(instr_addr_o);
      gnt_due_q.push_back(cyc + 1 + int'(rand_bits(2)));  // 1 to 4 cycles
    end
    check_true(gnt_addr_q.size() <= PF_DEPTH, "more reads outstanding than the prefetch depth");
    if (prev_valid && !prev_ready && !prev_kill) begin
      check_bit("id_valid_o", 1'b1, id_valid_o);
      check_word("id_pc_o", prev_pc, id_pc_o);
      check_word("id_instr_o", prev_instr, id_instr_o);
      check_bit("id_err_o", prev_err, id_err_o);
    end else if (prev_halt && !prev_kill) begin
      check_true(!id_valid_o, "new instruction reached ID while fetch was halted");
    end
    consumed = id_valid_o && id_ready_i && !kill_if_i;
    if (consumed) begin
      check_word("id_pc_o", exp_pc, id_pc_o);
      check_word("id_instr_o", mem_word(exp_pc), id_instr_o);
      check_bit("id_err_o", mem_err(exp_pc), id_err_o);
      exp_pc = exp_pc + 32'd4;
      n_out++;
    end
    prev_req   = instr_req_o;
    prev_gnt   = instr_gnt_i;
    prev_addr  = instr_addr_o;
    prev_valid = id_valid_o;
    prev_ready = id_ready_i;
    prev_kill  = kill_if_i;
    prev_halt  = halt_if_i;
    prev_pc    = id_pc_o;
    prev_instr = id_instr_o;
    prev_err   = id_err_o;
  endtask

  // Drive 1 ns after the edge and check late in the cycle
  task automatic run_cycle(input logic set, input logic ready, input logic halt);
    @(posedge clk);
    cyc++;
    if (cyc > TIMEOUT) begin
      $display("Run exceeded %0d cycles before all redirects were served", TIMEOUT);
      abort_run();
    end
    #1;
    if (set) pick_redirect();
    pc_set_i   = set;
    kill_if_i  = set;  // Redirect always kills IF
    id_ready_i = ready;
    halt_if_i  = halt;
    drive_bus();
    #2;
    sample_cycle();
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    int n_want;
    rst_n = 1'b0;
    pc_set_i = 1'b0;
    kill_if_i = 1'b0;
    halt_if_i = 1'b0;
    id_ready_i = 1'b0;
    pc_mux_i = PC_BOOT;
    irq_index_i = '0;
    mtvec_addr_i = '0;
    boot_addr_i = '0;
    jump_target_i = '0;
    branch_target_i = '0;
    mepc_i = '0;
    dpc_i = '0;
    dm_halt_addr_i = '0;
    dm_exception_addr_i = '0;
    instr_gnt_i = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i = '0;
    instr_err_i = 1'b0;
    for (int i = 1; i <= 10; i++) begin
      @(posedge clk);
      #1;
      if (i == 10) rst_n = 1'b1;
      #2;
      check_bit("id_valid_o", 1'b0, id_valid_o);
      check_bit("instr_req_o", 1'b0, instr_req_o);
      check_bit("csr_mtvec_init_o", 1'b0, csr_mtvec_init_o);
      check_bit("if_busy_o", 1'b0, if_busy_o);
    end
    repeat (3) run_cycle(1'b0, 1'b1, 1'b0);
    for (int r = 0; r < N_REDIR; r++) begin
      n_want = 1 + int'(rand_bits(4) % 12);
      n_out  = 0;
      run_cycle(1'b1, rand_bits(2) != 0, rand_bits(2) == 0);
      while (n_out < n_want) run_cycle(1'b0, rand_bits(2) != 0, rand_bits(2) == 0);
    end
    $display("test passed");
    $finish;
  end

endmodule

//--- tb.f
source/if_ctrl_pkg.sv
source/instr_bus_pkg.sv
source/fetch_if.sv
source/pc_select.sv
source/sync_fifo.sv
source/prefetch_unit.sv
source/if_id_reg.sv
source/if_stage.sv
sim/tb_if_stage.sv

//--- run.sh
#!/bin/sh
# Build and run the fetch stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f tb.f --top-module tb_if_stage \
  || { echo "Verilator build failed"; exit 1; }
out=$(./obj_dir/Vtb_if_stage)
echo "$out"
echo "$out" | grep -qx "test passed" && exit 0 || exit 1
